// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= cpu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assert (
	input logic                 clk,
	input logic                 rst_n,
	input cpu_ctrl_pkg::phase_e phase,  // sequencer phase counter
	input logic                 rd,
	input logic                 wr,
	input logic                 en_alu,
	input logic                 ld_acc,
	input logic                 a_sel
);

	// single memory port, never both strobes
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd && wr))
		else $error("read and write strobes high together");

	// acc write exactly one cycle after the alu latch
	a_ld_acc_after_alu: assert property (@(posedge clk) disable iff (!rst_n)
		ld_acc |-> ($past(en_alu) && !$past(ld_acc)))
		else $error("ld_acc without en_alu one cycle before");

	// fetch always uses the pc
	a_fetch_sel_pc: assert property (@(posedge clk) disable iff (!rst_n)
		((phase == cpu_ctrl_pkg::PH_FETCH_HI) || (phase == cpu_ctrl_pkg::PH_FETCH_LO))
		|-> !a_sel)
		else $error("operand address selected during fetch");

endmodule

bind cpu_sequencer cpu_assert u_assert (
	.clk    (clk),
	.rst_n  (rst_n),
	.phase  (phase),
	.rd     (ctrl.rd),
	.wr     (ctrl.wr),
	.en_alu (ctrl.en_alu),
	.ld_acc (ctrl.ld_acc),
	.a_sel  (ctrl.a_sel)
);

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;

	logic                   clk;
	logic                   rst_n;
	logic [`CPU_ADDR_W-1:0] mem_addr;
	logic                   mem_rd;
	logic                   mem_wr;
	logic [`CPU_DATA_W-1:0] mem_wdata;
	logic [`CPU_DATA_W-1:0] mem_rdata;

	logic [`CPU_DATA_W-1:0] mem [0:(1<<`CPU_ADDR_W)-1]; // 8 KB byte memory

	logic [2:0]             ph;        // expected phase of the current cycle
	logic                   started;   // first fetch seen
	logic [`CPU_ADDR_W-1:0] model_pc;  // address of current instruction
	logic [`CPU_DATA_W-1:0] model_acc;
	logic [`CPU_DATA_W-1:0] cur_hi;
	logic [`CPU_DATA_W-1:0] cur_lo;
	cpu_isa_pkg::opcode_e   cur_opc;
	logic [`CPU_ADDR_W-1:0] cur_addr;
	logic                   reads_oper; // opcode fetches an operand
	logic                   is_sto;

	cpu_top u_cpu_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// instruction under execution straight from the program image
	assign cur_hi     = mem[model_pc];
	assign cur_lo     = mem[model_pc + `CPU_ADDR_W'(1)];
	assign cur_opc    = cpu_isa_pkg::opcode_e'(cur_hi[7:5]);
	assign cur_addr   = {cur_hi[4:0], cur_lo};
	assign reads_oper = (cur_opc == cpu_isa_pkg::LDA) || (cur_opc == cpu_isa_pkg::ADD) ||
			(cur_opc == cpu_isa_pkg::NXOR) || (cur_opc == cpu_isa_pkg::SFT);
	assign is_sto     = started && (ph == 3'd7) && (cur_opc == cpu_isa_pkg::STO);

	function automatic logic [7:0] expect_acc(input cpu_isa_pkg::opcode_e opc,
			input logic [7:0] acc, input logic [7:0] d);
		case (opc)
			cpu_isa_pkg::LDA:  return d;
			cpu_isa_pkg::ADD:  return acc + d; // mod 256
			cpu_isa_pkg::NXOR: return ~(acc ^ d);
			cpu_isa_pkg::SFT:  return {d[6:0], d[7]}; // rotate left
			default:           return acc;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ph <= 3'd7; // first clock after reset is phase 0
		end else begin
			ph <= ph + 3'd1;
		end
	end

	// reference model advances once per instruction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started   <= 1'b0;
			model_pc  <= `CPU_ADDR_W'(`CPU_RESET_PC);
			model_acc <= '0;
		end else begin
			if (ph == 3'd0) started <= 1'b1;
			if (started && ph == 3'd7) begin
				model_acc <= expect_acc(cur_opc, model_acc, mem[cur_addr]);
				case (cur_opc)
					cpu_isa_pkg::SKP:  model_pc <= model_pc + `CPU_ADDR_W'(4);
					cpu_isa_pkg::NJMP: model_pc <= cur_addr;
					default:           model_pc <= model_pc + `CPU_ADDR_W'(2);
				endcase
			end
		end
	end

	// memory model with one cycle read latency
	initial begin
		logic                   rd_s;
		logic                   wr_s;
		logic [`CPU_ADDR_W-1:0] a_s;
		logic [`CPU_DATA_W-1:0] wd_s;
		forever begin
			@(posedge clk);
			rd_s = mem_rd;
			wr_s = mem_wr;
			a_s  = mem_addr;
			wd_s = mem_wdata;
			#1;
			if (wr_s) mem[a_s] = wd_s;
			if (rd_s) mem_rdata = mem[a_s];
		end
	end

	task automatic report_mismatch(input string test, input logic [31:0] exp,
			input logic [31:0] act);
		$display("** Error %s: expected %0h, actual %0h", test, exp, act);
		$display("test failed");
		$fatal(1, "check %s", test);
	endtask

	a_idle: assert property (@(posedge clk) (!started && ph == 3'd7) |->
		({mem_rd, mem_wr, mem_wdata} == 10'd0))
		else report_mismatch("reset_idle", 32'd0,
			32'({$sampled(mem_rd), $sampled(mem_wr), $sampled(mem_wdata)}));
	a_fetch_hi: assert property (@(posedge clk) disable iff (!rst_n) (ph == 3'd0) |->
		({mem_rd, mem_addr} == {1'b1, model_pc}))
		else report_mismatch("fetch_hi", 32'({1'b1, $sampled(model_pc)}),
			32'({$sampled(mem_rd), $sampled(mem_addr)}));
	a_fetch_lo: assert property (@(posedge clk) disable iff (!rst_n) (ph == 3'd1) |->
		({mem_rd, mem_addr} == {1'b1, model_pc + `CPU_ADDR_W'(1)}))
		else report_mismatch("fetch_lo", 32'({1'b1, $sampled(model_pc) + `CPU_ADDR_W'(1)}),
			32'({$sampled(mem_rd), $sampled(mem_addr)}));
	a_oper_rd: assert property (@(posedge clk) disable iff (!rst_n)
		(started && ph == 3'd5) |-> (mem_rd == reads_oper) &&
		(!reads_oper || mem_addr == cur_addr))
		else report_mismatch("operand_read", 32'({$sampled(reads_oper), $sampled(cur_addr)}),
			32'({$sampled(mem_rd), $sampled(mem_addr)}));
	a_store: assert property (@(posedge clk) disable iff (!rst_n) is_sto |->
		({mem_wr, mem_addr, mem_wdata} == {1'b1, cur_addr, model_acc}))
		else report_mismatch("store",
			32'({1'b1, $sampled(cur_addr), $sampled(model_acc)}),
			32'({$sampled(mem_wr), $sampled(mem_addr), $sampled(mem_wdata)}));
	a_no_wr: assert property (@(posedge clk) disable iff (!rst_n) !is_sto |-> !mem_wr)
		else report_mismatch("stray_write", 32'd0, 32'($sampled(mem_addr)));

	task automatic load_instr(input logic [`CPU_ADDR_W-1:0] a, input cpu_isa_pkg::opcode_e opc,
			input logic [`CPU_ADDR_W-1:0] oper);
		mem[a]                   = {opc, oper[12:8]}; // high byte first
		mem[a + `CPU_ADDR_W'(1)] = oper[7:0];
	endtask

	task automatic wait_write(input logic [`CPU_ADDR_W-1:0] a);
		int  n;
		logic found;
		found = 1'b0;
		for (n = 0; n < 200 && !found; n++) begin
			@(negedge clk);
			found = mem_wr && (mem_addr == a);
		end
		if (!found) begin
			$display("timeout: no write seen at address %h", a);
			$display("test failed");
			$fatal(1, "timeout");
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		mem_rdata = '0;
		for (int i = 0; i < (1 << `CPU_ADDR_W); i++) begin
			mem[i] = 8'(i[7:0] ^ {3'd0, i[12:8]}); // depends on all address bits
		end
		mem[13'h100] = 8'($urandom(73)); // seeding call yields the first operand
		for (int i = 1; i < 4; i++) begin
			mem[13'h100 + i] = 8'($urandom); // remaining operands
		end
		load_instr(13'd0,  cpu_isa_pkg::LDA,  13'h100);
		load_instr(13'd2,  cpu_isa_pkg::ADD,  13'h101);
		load_instr(13'd4,  cpu_isa_pkg::STO,  13'h200);
		load_instr(13'd6,  cpu_isa_pkg::NXOR, 13'h102);
		load_instr(13'd8,  cpu_isa_pkg::STO,  13'h201);
		load_instr(13'd10, cpu_isa_pkg::SFT,  13'h103);
		load_instr(13'd12, cpu_isa_pkg::STO,  13'h202);
		load_instr(13'd14, cpu_isa_pkg::SKP,  13'h000);
		load_instr(13'd16, cpu_isa_pkg::STO,  13'h203); // skipped
		load_instr(13'd18, cpu_isa_pkg::NJMP, 13'd24);
		load_instr(13'd20, cpu_isa_pkg::STO,  13'h203); // jumped over
		load_instr(13'd22, cpu_isa_pkg::NOP,  13'h000);
		load_instr(13'd24, cpu_isa_pkg::STO,  13'h204); // final loop
		load_instr(13'd26, cpu_isa_pkg::NJMP, 13'd24);
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		wait_write(13'h200);
		wait_write(13'h201);
		wait_write(13'h202);
		wait_write(13'h204);
		wait_write(13'h204); // loop came round again
		@(negedge clk);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_top.f
+incdir+include
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/cpu_ctrl_if.sv
src/cpu_sequencer.sv
src/cpu_addr_gen.sv
src/cpu_instr_reg.sv
src/cpu_alu_acc.sv
src/cpu_top.sv
bench/cpu_assert.sv
bench/cpu_tb.sv

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// byte address into the external memory
`define CPU_ADDR_W   13

`define CPU_DATA_W   8  // data bus and accumulator

// first fetch address
`define CPU_RESET_PC 0

`endif

// File: src/cpu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_addr_gen (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_ADDR_W-1:0] oper_addr, // jump target / operand
	cpu_ctrl_if.addr               ctrl,
	output logic [`CPU_ADDR_W-1:0] mem_addr
);

	logic [`CPU_ADDR_W-1:0] pc; // next fetch address

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `CPU_ADDR_W'(`CPU_RESET_PC);
		end else if (ctrl.ld_pc) begin
			pc <= oper_addr; // njmp
		end else if (ctrl.en_inc) begin
			pc <= pc + 1'b1; // fetch and skp, wraps at top of memory
		end
	end

	// address mux
	assign mem_addr = ctrl.a_sel ? oper_addr : pc;

endmodule

`default_nettype wire

// File: src/cpu_alu_acc.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_alu_acc (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cpu_isa_pkg::opcode_e   opcode,
	input  logic [`CPU_DATA_W-1:0] mem_rdata, // operand byte
	cpu_ctrl_if.alu                ctrl,
	output logic [`CPU_DATA_W-1:0] acc
);

	logic [`CPU_DATA_W-1:0] alu_res; // combinational result
	logic [`CPU_DATA_W-1:0] alu_q;   // result held until ld_acc

	always_comb begin
		case (opcode)
			cpu_isa_pkg::LDA:  alu_res = mem_rdata;
			cpu_isa_pkg::ADD:  alu_res = acc + mem_rdata; // carry dropped
			cpu_isa_pkg::NXOR: alu_res = ~(acc ^ mem_rdata);
			cpu_isa_pkg::SFT:  alu_res = {mem_rdata[`CPU_DATA_W-2:0],
					mem_rdata[`CPU_DATA_W-1]}; // rotate left by one
			default:           alu_res = acc; // no acc update on other opcodes
		endcase
	end

	// operand is on mem_rdata only during exec
	always_ff @(posedge clk) begin
		if (ctrl.en_alu) begin
			alu_q <= alu_res;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (ctrl.ld_acc) begin
			acc <= alu_q; // one phase after the latch
		end
	end

endmodule

`default_nettype wire

// File: src/cpu_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_ctrl_if;

	logic en_inc; // pc + 1
	logic ld_pc;  // pc <= operand address
	logic ld_ir;  // capture read byte into ir
	logic en_alu; // latch operand, compute
	logic ld_acc; // alu result into acc
	logic a_sel;  // 0 pc, 1 operand address
	logic rd;     // memory read strobe
	logic wr;     // memory write strobe

	// sequencer drives the whole word
	modport seq (
		output en_inc, ld_pc, ld_ir, en_alu, ld_acc, a_sel, rd, wr
	);

	modport addr (input en_inc, ld_pc, a_sel); // pc and address mux

	modport ir (input ld_ir); // instruction register

	modport alu (input en_alu, ld_acc); // alu and accumulator

endinterface

`default_nettype wire

// File: src/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

	// eight phases per instruction
	typedef enum logic [2:0] {
		PH_FETCH_HI  = 3'd0, // read high byte
		PH_FETCH_LO  = 3'd1, // read low byte, latch high
		PH_LOAD_LO   = 3'd2, // latch low byte
		PH_DECODE    = 3'd3, // opcode now stable
		PH_OPER_ADDR = 3'd4, // operand address on the bus
		PH_OPER_RD   = 3'd5, // operand read strobe
		PH_EXEC      = 3'd6, // alu latches read data
		PH_WRITE     = 3'd7  // acc, store, jump
	} phase_e;

endpackage

`default_nettype wire

// File: src/cpu_instr_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_instr_reg (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_DATA_W-1:0] mem_rdata,
	cpu_ctrl_if.ir                 ctrl,
	output cpu_isa_pkg::opcode_e   opcode,
	output logic [`CPU_ADDR_W-1:0] oper_addr
);

	logic [2*`CPU_DATA_W-1:0] ir;   // high byte arrives first
	logic                     byte_ptr; // 0 high half, 1 low half

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir       <= '0; // nop
			byte_ptr <= 1'b0;
		end else if (ctrl.ld_ir) begin
			if (byte_ptr) begin
				ir[`CPU_DATA_W-1:0] <= mem_rdata;
			end else begin
				ir[2*`CPU_DATA_W-1:`CPU_DATA_W] <= mem_rdata;
			end
			byte_ptr <= !byte_ptr; // two loads per instruction
		end
	end

	// field split
	assign opcode    = cpu_isa_pkg::opcode_e'(ir[cpu_isa_pkg::OPC_MSB -: cpu_isa_pkg::OPC_W]);
	assign oper_addr = ir[`CPU_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	localparam int OPC_W   = 3;  // opcode bits
	localparam int OPC_MSB = 15; // opcode sits at the top of the instruction

	// top three bits of the high instruction byte
	typedef enum logic [OPC_W-1:0] {
		NOP  = 3'd0, // no operation
		LDA  = 3'd1, // acc = mem[addr]
		STO  = 3'd2, // mem[addr] = acc
		ADD  = 3'd3, // acc = acc + mem[addr]
		NXOR = 3'd4, // acc = ~(acc ^ mem[addr])
		SFT  = 3'd5, // acc = rotl(mem[addr])
		SKP  = 3'd6, // skip next instruction
		NJMP = 3'd7  // pc = addr
	} opcode_e;

endpackage

`default_nettype wire

// File: src/cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_isa_pkg::opcode_e opcode, // from instruction register
	cpu_ctrl_if.seq              ctrl
);

	cpu_ctrl_pkg::phase_e phase;

	logic fetch;     // phases 0 and 1
	logic alu_op;    // opcode reads an operand into acc
	logic rd_oper_q; // operand read, one phase after address
	logic ld_acc_q;  // acc write, one phase after exec

	// reset parks the counter on the last phase with a NOP in the ir,
	// so nothing strobes until the first clock moves it to phase 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= cpu_ctrl_pkg::PH_WRITE;
		end else begin
			phase <= cpu_ctrl_pkg::phase_e'(phase + 3'd1); // wraps 7 -> 0
		end
	end

	assign fetch  = (phase == cpu_ctrl_pkg::PH_FETCH_HI) ||
			(phase == cpu_ctrl_pkg::PH_FETCH_LO);
	assign alu_op = (opcode == cpu_isa_pkg::LDA) || (opcode == cpu_isa_pkg::ADD) ||
			(opcode == cpu_isa_pkg::NXOR) || (opcode == cpu_isa_pkg::SFT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_oper_q <= 1'b0;
			ld_acc_q  <= 1'b0;
		end else begin
			rd_oper_q <= alu_op && (phase == cpu_ctrl_pkg::PH_OPER_ADDR); // high in phase 5
			ld_acc_q  <= alu_op && (phase == cpu_ctrl_pkg::PH_EXEC);      // high in phase 7
		end
	end

	// fetch reads two bytes at pc, pc + 1
	assign ctrl.rd    = fetch || rd_oper_q;
	assign ctrl.a_sel = !fetch; // operand address outside fetch

	// skp bumps pc twice more, past the next instruction
	assign ctrl.en_inc = fetch ||
			((opcode == cpu_isa_pkg::SKP) &&
			 ((phase == cpu_ctrl_pkg::PH_EXEC) || (phase == cpu_ctrl_pkg::PH_WRITE)));

	// read data lags rd by one clock
	assign ctrl.ld_ir = (phase == cpu_ctrl_pkg::PH_FETCH_LO) ||
			(phase == cpu_ctrl_pkg::PH_LOAD_LO);

	assign ctrl.en_alu = (phase == cpu_ctrl_pkg::PH_EXEC); // operand data valid here
	assign ctrl.ld_acc = ld_acc_q;

	assign ctrl.ld_pc = (opcode == cpu_isa_pkg::NJMP) && (phase == cpu_ctrl_pkg::PH_WRITE);
	assign ctrl.wr    = (opcode == cpu_isa_pkg::STO) && (phase == cpu_ctrl_pkg::PH_WRITE);

endmodule

`default_nettype wire

// File: src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_top (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic [`CPU_ADDR_W-1:0] mem_addr,
	output logic                   mem_rd,    // read strobe, data next clock
	output logic                   mem_wr,    // write strobe
	output logic [`CPU_DATA_W-1:0] mem_wdata,
	input  logic [`CPU_DATA_W-1:0] mem_rdata
);

	cpu_isa_pkg::opcode_e   opcode;    // ir -> sequencer, alu
	logic [`CPU_ADDR_W-1:0] oper_addr; // ir -> address generator
	logic [`CPU_DATA_W-1:0] acc;

	cpu_ctrl_if ctrl ();

	cpu_sequencer u_seq (
		.clk    (clk),
		.rst_n  (rst_n),
		.opcode (opcode),
		.ctrl   (ctrl.seq)
	);

	cpu_addr_gen u_addr (
		.clk       (clk),
		.rst_n     (rst_n),
		.oper_addr (oper_addr),
		.ctrl      (ctrl.addr),
		.mem_addr  (mem_addr)
	);

	cpu_instr_reg u_ir (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_rdata (mem_rdata),
		.ctrl      (ctrl.ir),
		.opcode    (opcode),
		.oper_addr (oper_addr)
	);

	cpu_alu_acc u_alu (
		.clk       (clk),
		.rst_n     (rst_n),
		.opcode    (opcode),
		.mem_rdata (mem_rdata),
		.ctrl      (ctrl.alu),
		.acc       (acc)
	);

	assign mem_rd    = ctrl.rd;
	assign mem_wr    = ctrl.wr;
	assign mem_wdata = acc; // sto writes the accumulator

endmodule

`default_nettype wire
